// ==== src/ext_axi_pkg.sv ====
//************************************************
// AXI write channel definitions
// Widths and vector types of the master write side
//************************************************

package ext_axi_pkg;

   //************************************************
   // Channel widths
   //************************************************

   // Byte address
   localparam int unsigned AXI_ADDR_WIDTH = 32;
   // One 64-bit word per beat
   localparam int unsigned AXI_DATA_WIDTH = 64;
   localparam int unsigned AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
   localparam int unsigned AXI_ID_WIDTH   = 4;

   //************************************************
   // Channel vectors
   //************************************************

   typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
   typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
   typedef logic [AXI_STRB_WIDTH-1:0] axi_strb_t;
   typedef logic [AXI_ID_WIDTH-1:0]   axi_id_t;

   // Burst length in beats minus one
   typedef logic [7:0]                axi_len_t;

endpackage

// ==== src/ext_cmd_pkg.sv ====
//************************************************
// Write command definitions
// Command fields, transaction and stream ids
//************************************************

package ext_cmd_pkg;

   //************************************************
   // Field widths and sizes
   //************************************************

   // Address of a 64-bit word
   localparam int unsigned EXT_ADD_WIDTH   = 29;
   // Byte length, 2048 wraps to zero
   localparam int unsigned LEN_WIDTH       = 11;
   localparam int unsigned TID_WIDTH       = 4;
   localparam int unsigned SID_WIDTH       = 1;
   localparam int unsigned CMD_QUEUE_DEPTH = 2;
   // One id per value of the tid vector
   localparam int unsigned NUM_TID         = 16;

   //************************************************
   // Field vectors
   //************************************************

   typedef logic [EXT_ADD_WIDTH-1:0] ext_add_t;
   typedef logic [LEN_WIDTH-1:0]     cmd_len_t;
   typedef logic [TID_WIDTH-1:0]     tid_t;
   typedef logic [SID_WIDTH-1:0]     sid_t;

endpackage

// ==== src/ext_cmd_queue.sv ====
//************************************************
// Write command queue
// Small FIFO holding host commands until issued
//************************************************
`timescale 1ns/1ps

module ext_cmd_queue (
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  ext_cmd_pkg::ext_add_t push_add_i,
   input  ext_cmd_pkg::cmd_len_t push_len_i,
   input  ext_cmd_pkg::sid_t     push_sid_i,
   input  logic                  push_req_i,
   output logic                  push_gnt_o,
   output ext_cmd_pkg::ext_add_t pop_add_o,
   output ext_cmd_pkg::cmd_len_t pop_len_o,
   output ext_cmd_pkg::sid_t     pop_sid_o,
   output logic                  pop_valid_o,
   input  logic                  pop_i
);
   import ext_cmd_pkg::*;

   ext_add_t                             add_mem [CMD_QUEUE_DEPTH];
   cmd_len_t                             len_mem [CMD_QUEUE_DEPTH];
   sid_t                                 sid_mem [CMD_QUEUE_DEPTH];
   logic [$clog2(CMD_QUEUE_DEPTH)-1:0]   wr_ptr_q;
   logic [$clog2(CMD_QUEUE_DEPTH)-1:0]   rd_ptr_q;
   logic [$clog2(CMD_QUEUE_DEPTH+1)-1:0] count_q;
   logic                                 push;
   logic                                 pop;

   assign push_gnt_o  = (count_q != CMD_QUEUE_DEPTH);
   assign pop_valid_o = (count_q != '0);
   assign push        = push_req_i & push_gnt_o;
   assign pop         = pop_i & pop_valid_o;

   // Oldest entry sits at the read pointer
   assign pop_add_o = add_mem[rd_ptr_q];
   assign pop_len_o = len_mem[rd_ptr_q];
   assign pop_sid_o = sid_mem[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (push) begin
         add_mem[wr_ptr_q] <= push_add_i;
         len_mem[wr_ptr_q] <= push_len_i;
         sid_mem[wr_ptr_q] <= push_sid_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == CMD_QUEUE_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == CMD_QUEUE_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
         end
         // Fill level only moves on a lone push or pop
         if (push && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

// ==== src/ext_tid_gen.sv ====
//************************************************
// Transaction id pool
// Hands out free ids, frees them on write response
//************************************************
`timescale 1ns/1ps

module ext_tid_gen (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  logic              alloc_i,
   output ext_cmd_pkg::tid_t tid_o,
   output logic              tid_valid_o,
   input  logic              release_i,
   input  ext_cmd_pkg::tid_t release_tid_i
);
   import ext_cmd_pkg::*;

   tid_t               tid_q;
   logic [NUM_TID-1:0] busy_q;
   logic [NUM_TID-1:0] busy_d;

   // Candidate id is usable only once its last burst has been answered
   assign tid_o       = tid_q;
   assign tid_valid_o = ~busy_q[tid_q];

   // Responses come back in any order, so each id has its own flag
   always_comb begin
      busy_d = busy_q;
      if (release_i) begin
         busy_d[release_tid_i] = 1'b0;
      end
      if (alloc_i) begin
         busy_d[tid_q] = 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tid_q  <= '0;
         busy_q <= '0;
      end else begin
         busy_q <= busy_d;
         // Pool size equals the id range, the counter wraps by itself
         if (alloc_i) begin
            tid_q <= tid_q + 1'b1;
         end
      end
   end

endmodule

// ==== src/ext_sid_buf.sv ====
//************************************************
// Stream id table
// Remembers the stream of each open transaction
//************************************************
`timescale 1ns/1ps

module ext_sid_buf (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  logic              wr_i,
   input  ext_cmd_pkg::tid_t wr_tid_i,
   input  ext_cmd_pkg::sid_t wr_sid_i,
   input  logic              rd_i,
   input  ext_cmd_pkg::tid_t rd_tid_i,
   output logic              synch_req_o,
   output ext_cmd_pkg::sid_t synch_sid_o
);
   import ext_cmd_pkg::*;

   sid_t sid_tab [NUM_TID];

   // Entry written when the id is handed out
   always_ff @(posedge clk_i) begin
      if (wr_i) begin
         sid_tab[wr_tid_i] <= wr_sid_i;
      end
      if (rd_i) begin
         synch_sid_o <= sid_tab[rd_tid_i];
      end
   end

   // One-cycle pulse after each response
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         synch_req_o <= 1'b0;
      end else begin
         synch_req_o <= rd_i;
      end
   end

endmodule

// ==== src/ext_tx_fsm.sv ====
//************************************************
// Write burst FSM
// Issues AW for a command, then streams its beats
// through a one-entry W register
//************************************************
`timescale 1ns/1ps

module ext_tx_fsm (
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   input  ext_cmd_pkg::ext_add_t  cmd_add_i,
   input  ext_cmd_pkg::cmd_len_t  cmd_len_i,
   input  logic                   cmd_valid_i,
   output logic                   cmd_pop_o,
   input  ext_cmd_pkg::tid_t      tid_i,
   input  logic                   tid_valid_i,
   output logic                   aw_valid_o,
   output ext_axi_pkg::axi_addr_t aw_addr_o,
   output ext_axi_pkg::axi_len_t  aw_len_o,
   output ext_axi_pkg::axi_id_t   aw_id_o,
   input  logic                   aw_ready_i,
   input  ext_axi_pkg::axi_data_t tx_data_dat_i,
   input  ext_axi_pkg::axi_strb_t tx_data_strb_i,
   output logic                   tx_data_req_o,
   input  logic                   tx_data_gnt_i,
   output logic                   w_valid_o,
   output ext_axi_pkg::axi_data_t w_data_o,
   output ext_axi_pkg::axi_strb_t w_strb_o,
   output logic                   w_last_o,
   input  logic                   w_ready_i
);
   import ext_axi_pkg::*;
   import ext_cmd_pkg::*;

   typedef enum logic [1:0] {IDLE, ADDR, DATA} state_t;

   state_t   state_q;
   axi_len_t beat_cnt_q;
   logic     req_done_q;
   logic     beat_take;
   logic     w_take;

   assign cmd_pop_o     = (state_q == IDLE) & cmd_valid_i & tid_valid_i;
   assign w_take        = w_valid_o & w_ready_i;
   // Fetch a beat when the W register is free or drains this cycle
   assign tx_data_req_o = (state_q == DATA) & ~req_done_q & (~w_valid_o | w_ready_i);
   assign beat_take     = tx_data_req_o & tx_data_gnt_i;

   //************************************************
   // Control
   //************************************************
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= IDLE;
         aw_valid_o <= 1'b0;
         w_valid_o  <= 1'b0;
         beat_cnt_q <= '0;
         req_done_q <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (cmd_pop_o) begin
                  state_q    <= ADDR;
                  aw_valid_o <= 1'b1;
               end
            end
            ADDR: begin
               if (aw_ready_i) begin
                  state_q    <= DATA;
                  aw_valid_o <= 1'b0;
                  beat_cnt_q <= aw_len_o;
                  req_done_q <= 1'b0;
               end
            end
            DATA: begin
               // Burst ends with the last W handshake
               if (w_take && w_last_o) begin
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
         if (beat_take) begin
            w_valid_o <= 1'b1;
            if (beat_cnt_q == '0) begin
               req_done_q <= 1'b1;
            end else begin
               beat_cnt_q <= beat_cnt_q - 1'b1;
            end
         end else if (w_take) begin
            w_valid_o <= 1'b0;
         end
      end
   end

   //************************************************
   // AW and W payload
   //************************************************
   always_ff @(posedge clk_i) begin
      if (cmd_pop_o) begin
         aw_addr_o <= {cmd_add_i, 3'b000};
         // 8-byte beats, 2048 bytes wraps to 256 beats
         aw_len_o  <= cmd_len_i[LEN_WIDTH-1:3] - 8'd1;
         aw_id_o   <= tid_i;
      end
      if (beat_take) begin
         w_data_o <= tx_data_dat_i;
         w_strb_o <= tx_data_strb_i;
         w_last_o <= (beat_cnt_q == '0);
      end
   end

endmodule

// ==== src/ext_tx_unit.sv ====
//************************************************
// External DMA write unit
// Queues write commands, issues AXI4 write bursts
// and signals completion per stream
//************************************************
`timescale 1ns/1ps

module ext_tx_unit (
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   // Host commands
   input  ext_cmd_pkg::ext_add_t  ext_tx_add_i,
   input  ext_cmd_pkg::cmd_len_t  ext_tx_len_i,
   input  ext_cmd_pkg::sid_t      ext_tx_sid_i,
   input  logic                   ext_tx_req_i,
   output logic                   ext_tx_gnt_o,
   // Local write data
   input  ext_axi_pkg::axi_data_t tx_data_dat_i,
   input  ext_axi_pkg::axi_strb_t tx_data_strb_i,
   output logic                   tx_data_req_o,
   input  logic                   tx_data_gnt_i,
   // AXI write address
   output logic                   axi_master_aw_valid_o,
   output ext_axi_pkg::axi_addr_t axi_master_aw_addr_o,
   output ext_axi_pkg::axi_len_t  axi_master_aw_len_o,
   output ext_axi_pkg::axi_id_t   axi_master_aw_id_o,
   input  logic                   axi_master_aw_ready_i,
   // AXI write data
   output logic                   axi_master_w_valid_o,
   output ext_axi_pkg::axi_data_t axi_master_w_data_o,
   output ext_axi_pkg::axi_strb_t axi_master_w_strb_o,
   output logic                   axi_master_w_last_o,
   input  logic                   axi_master_w_ready_i,
   // AXI write response
   input  logic                   axi_master_b_valid_i,
   input  ext_axi_pkg::axi_id_t   axi_master_b_id_i,
   output logic                   axi_master_b_ready_o,
   // Completion
   output logic                   tx_synch_req_o,
   output ext_cmd_pkg::sid_t      tx_synch_sid_o
);
   import ext_cmd_pkg::*;

   ext_add_t cmd_add;
   cmd_len_t cmd_len;
   sid_t     cmd_sid;
   logic     cmd_valid;
   logic     cmd_pop;
   tid_t     tid;
   logic     tid_valid;
   logic     b_hs;

   // Responses are always accepted
   assign axi_master_b_ready_o = 1'b1;
   assign b_hs                 = axi_master_b_valid_i & axi_master_b_ready_o;

   ext_cmd_queue i_cmd_queue (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .push_add_i  (ext_tx_add_i),
      .push_len_i  (ext_tx_len_i),
      .push_sid_i  (ext_tx_sid_i),
      .push_req_i  (ext_tx_req_i),
      .push_gnt_o  (ext_tx_gnt_o),
      .pop_add_o   (cmd_add),
      .pop_len_o   (cmd_len),
      .pop_sid_o   (cmd_sid),
      .pop_valid_o (cmd_valid),
      .pop_i       (cmd_pop)
   );

   // Id taken on pop, returned on B
   ext_tid_gen i_tid_gen (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .alloc_i       (cmd_pop),
      .tid_o         (tid),
      .tid_valid_o   (tid_valid),
      .release_i     (b_hs),
      .release_tid_i (tid_t'(axi_master_b_id_i))
   );

   ext_sid_buf i_sid_buf (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .wr_i        (cmd_pop),
      .wr_tid_i    (tid),
      .wr_sid_i    (cmd_sid),
      .rd_i        (b_hs),
      .rd_tid_i    (tid_t'(axi_master_b_id_i)),
      .synch_req_o (tx_synch_req_o),
      .synch_sid_o (tx_synch_sid_o)
   );

   ext_tx_fsm i_tx_fsm (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .cmd_add_i      (cmd_add),
      .cmd_len_i      (cmd_len),
      .cmd_valid_i    (cmd_valid),
      .cmd_pop_o      (cmd_pop),
      .tid_i          (tid),
      .tid_valid_i    (tid_valid),
      .aw_valid_o     (axi_master_aw_valid_o),
      .aw_addr_o      (axi_master_aw_addr_o),
      .aw_len_o       (axi_master_aw_len_o),
      .aw_id_o        (axi_master_aw_id_o),
      .aw_ready_i     (axi_master_aw_ready_i),
      .tx_data_dat_i  (tx_data_dat_i),
      .tx_data_strb_i (tx_data_strb_i),
      .tx_data_req_o  (tx_data_req_o),
      .tx_data_gnt_i  (tx_data_gnt_i),
      .w_valid_o      (axi_master_w_valid_o),
      .w_data_o       (axi_master_w_data_o),
      .w_strb_o       (axi_master_w_strb_o),
      .w_last_o       (axi_master_w_last_o),
      .w_ready_i      (axi_master_w_ready_i)
   );

endmodule

// ==== sim/ext_tx_unit_sva.sv ====
//************************************************
// AXI write channel assertions
// Payload stability, last placement, AW before W
//************************************************
`timescale 1ns/1ps

module ext_tx_unit_sva (
   input logic                   clk_i,
   input logic                   arst_n_i,
   input logic                   axi_master_aw_valid_o,
   input ext_axi_pkg::axi_addr_t axi_master_aw_addr_o,
   input ext_axi_pkg::axi_len_t  axi_master_aw_len_o,
   input ext_axi_pkg::axi_id_t   axi_master_aw_id_o,
   input logic                   axi_master_aw_ready_i,
   input logic                   axi_master_w_valid_o,
   input ext_axi_pkg::axi_data_t axi_master_w_data_o,
   input ext_axi_pkg::axi_strb_t axi_master_w_strb_o,
   input logic                   axi_master_w_last_o,
   input logic                   axi_master_w_ready_i
);
   import ext_axi_pkg::*;

   logic [$bits(axi_len_t):0] beats_left_q;
   logic                      aw_seen_q;
   logic                      aw_hs;
   logic                      w_hs;

   assign aw_hs = axi_master_aw_valid_o & axi_master_aw_ready_i;
   assign w_hs  = axi_master_w_valid_o & axi_master_w_ready_i;

   // Beats still owed by the current burst
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         beats_left_q <= '0;
         aw_seen_q    <= 1'b0;
      end else if (aw_hs) begin
         beats_left_q <= axi_master_aw_len_o + 1'b1;
         aw_seen_q    <= 1'b1;
      end else if (w_hs) begin
         beats_left_q <= beats_left_q - 1'b1;
      end
   end

   aw_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      axi_master_aw_valid_o && !axi_master_aw_ready_i |=> axi_master_aw_valid_o &&
      $stable(axi_master_aw_addr_o) && $stable(axi_master_aw_len_o) &&
      $stable(axi_master_aw_id_o))
      else $error("AW payload changed while waiting for ready");

   w_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      axi_master_w_valid_o && !axi_master_w_ready_i |=> axi_master_w_valid_o &&
      $stable(axi_master_w_data_o) && $stable(axi_master_w_strb_o) &&
      $stable(axi_master_w_last_o))
      else $error("W payload changed while waiting for ready");

   w_last_final: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      w_hs |-> (axi_master_w_last_o == (beats_left_q == 1)))
      else $error("W last does not match the final beat of the burst");

   w_after_aw: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !aw_seen_q |-> !axi_master_w_valid_o)
      else $error("W valid raised before the first AW handshake");

endmodule

bind ext_tx_unit ext_tx_unit_sva i_sva (.*);

// ==== sim/tb_ext_tx_unit.sv ====
//************************************************
// Testbench for the external DMA write unit
// Host, write-data source and AXI slave models
// with a reference-based comparator
//************************************************
`timescale 1ns/1ps

module tb_ext_tx_unit;
   import ext_axi_pkg::*;
   import ext_cmd_pkg::*;

   localparam int NUM_CMDS = 40;

   logic      clk_i;
   logic      arst_n_i;
   ext_add_t  ext_tx_add_i;
   cmd_len_t  ext_tx_len_i;
   sid_t      ext_tx_sid_i;
   logic      ext_tx_req_i;
   logic      ext_tx_gnt_o;
   axi_data_t tx_data_dat_i;
   axi_strb_t tx_data_strb_i;
   logic      tx_data_req_o;
   logic      tx_data_gnt_i;
   logic      axi_master_aw_valid_o;
   axi_addr_t axi_master_aw_addr_o;
   axi_len_t  axi_master_aw_len_o;
   axi_id_t   axi_master_aw_id_o;
   logic      axi_master_aw_ready_i;
   logic      axi_master_w_valid_o;
   axi_data_t axi_master_w_data_o;
   axi_strb_t axi_master_w_strb_o;
   logic      axi_master_w_last_o;
   logic      axi_master_w_ready_i;
   logic      axi_master_b_valid_i;
   axi_id_t   axi_master_b_id_i;
   logic      axi_master_b_ready_o;
   logic      tx_synch_req_o;
   sid_t      tx_synch_sid_o;

   // Command set and scoreboard state
   ext_add_t    cmd_add [NUM_CMDS];
   int          cmd_bytes [NUM_CMDS];
   sid_t        cmd_sid [NUM_CMDS];
   sid_t        sid_of_id [NUM_TID];
   logic [71:0] beat_q [$];
   axi_id_t     aw_id_q [$];
   axi_id_t     b_pend_q [$];
   axi_data_t   src_cnt = '0;
   int          total_beats = 0;
   int          n_granted = 0;
   int          aw_count = 0;
   int          b_count = 0;
   int          w_count = 0;
   int          w_burst = 0;
   int          w_beat = 0;
   int          synch_count = 0;
   int          n_checks = 0;
   int          n_errors = 0;
   logic        aw_en = 1'b0;
   logic        b_en = 1'b0;
   logic        synch_due = 1'b0;
   sid_t        synch_exp;
   logic        cmds_ready = 1'b0;

   ext_tx_unit i_dut (.*);

   // Expected AW fields and beat count of one command
   function automatic void ref_burst(input ext_add_t add, input int bytes,
                                     output axi_addr_t exp_addr, output axi_len_t exp_len,
                                     output int beats);
      beats    = bytes / 8;
      exp_addr = axi_addr_t'(add) * 8;
      exp_len  = axi_len_t'(beats - 1);
   endfunction

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      n_checks++;
      assert (exp === act) else begin
         n_errors++;
         $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
      end
   endtask

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   //************************************************
   // Sequence of test phases
   //************************************************
   initial begin
      void'($urandom(32'hb25c));
      arst_n_i              = 1'b0;
      ext_tx_add_i          = '0;
      ext_tx_len_i          = '0;
      ext_tx_sid_i          = '0;
      ext_tx_req_i          = 1'b0;
      tx_data_dat_i         = '0;
      tx_data_strb_i        = '0;
      tx_data_gnt_i         = 1'b0;
      axi_master_aw_ready_i = 1'b0;
      axi_master_w_ready_i  = 1'b0;
      axi_master_b_valid_i  = 1'b0;
      axi_master_b_id_i     = '0;
      // One full 2048-byte burst among short ones
      for (int i = 0; i < NUM_CMDS; i++) begin
         cmd_add[i]   = ext_add_t'($urandom);
         cmd_bytes[i] = (i == 20) ? 2048 : 8 * (1 + $urandom % 16);
         cmd_sid[i]   = sid_t'($urandom);
         total_beats += cmd_bytes[i] / 8;
      end
      cmds_ready = 1'b1;
      repeat (8) @(posedge clk_i);
      arst_n_i <= 1'b1;

      // With AW stalled the FSM holds one command and the queue two
      repeat (20) @(negedge clk_i);
      repeat (10) begin
         @(negedge clk_i);
         check_value("gnt_while_aw_stalled", 1'b0, ext_tx_gnt_o);
      end
      check_value("grants_while_aw_stalled", 3, n_granted);
      aw_en = 1'b1;

      // No B responses yet, so the id pool runs dry at 16
      wait (aw_count == NUM_TID);
      repeat (400) @(negedge clk_i);
      check_value("aw_without_b", NUM_TID, aw_count);
      b_en = 1'b1;

      wait (synch_count == NUM_CMDS);
      repeat (20) @(negedge clk_i);
      check_value("aw_total", NUM_CMDS, aw_count);
      check_value("burst_total", NUM_CMDS, w_burst);
      check_value("beat_total", total_beats, w_count);
      check_value("beats_left_over", 0, beat_q.size());
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      wait (cmds_ready === 1'b1);
      repeat (total_beats * 50 + 2000) @(posedge clk_i);
      $display("ERROR: watchdog expired with %0d of %0d completions seen",
               synch_count, NUM_CMDS);
      $display("Simulation FAILED");
      $finish;
   end

   //************************************************
   // Host, data source and AXI slave models
   //************************************************
   initial begin : cmd_driver
      wait (arst_n_i === 1'b1);
      while (n_granted < NUM_CMDS) begin
         @(posedge clk_i);
         if (ext_tx_req_i && ext_tx_gnt_o) begin
            n_granted++;
         end
         if (n_granted < NUM_CMDS) begin
            ext_tx_req_i <= 1'b1;
            ext_tx_add_i <= cmd_add[n_granted];
            ext_tx_len_i <= cmd_len_t'(cmd_bytes[n_granted]);
            ext_tx_sid_i <= cmd_sid[n_granted];
         end else begin
            ext_tx_req_i <= 1'b0;
         end
      end
   end

   // Data is a running beat counter
   always @(posedge clk_i) begin : data_source
      if (tx_data_req_o && tx_data_gnt_i) begin
         beat_q.push_back({tx_data_strb_i, tx_data_dat_i});
         src_cnt = src_cnt + 1'b1;
      end
      tx_data_gnt_i  <= ($urandom % 3) != 0;
      tx_data_dat_i  <= src_cnt;
      tx_data_strb_i <= axi_strb_t'($urandom);
   end

   always @(posedge clk_i) begin : axi_slave
      int pick;
      if (axi_master_aw_valid_o && axi_master_aw_ready_i) begin
         aw_id_q.push_back(axi_master_aw_id_o);
      end
      if (axi_master_w_valid_o && axi_master_w_ready_i && axi_master_w_last_o) begin
         b_pend_q.push_back(aw_id_q.pop_front());
      end
      axi_master_aw_ready_i <= aw_en && ($urandom % 2);
      axi_master_w_ready_i  <= ($urandom % 4) != 0;
      // Random pick from the pending list gives out-of-order responses
      if (b_en && b_pend_q.size() > 0 && ($urandom % 3) == 0) begin
         pick = $urandom % b_pend_q.size();
         axi_master_b_id_i    <= b_pend_q[pick];
         axi_master_b_valid_i <= 1'b1;
         b_pend_q.delete(pick);
      end else begin
         axi_master_b_valid_i <= 1'b0;
      end
   end

   //************************************************
   // Comparator
   //************************************************
   always @(posedge clk_i) begin : comparator
      axi_addr_t   exp_addr;
      axi_len_t    exp_len;
      int          beats;
      logic [71:0] beat;
      // Bursts must follow command order
      if (axi_master_aw_valid_o && axi_master_aw_ready_i) begin
         ref_burst(cmd_add[aw_count], cmd_bytes[aw_count], exp_addr, exp_len, beats);
         check_value("aw_addr", exp_addr, axi_master_aw_addr_o);
         check_value("aw_len", exp_len, axi_master_aw_len_o);
         // Ids come from a wrapping counter, one per command
         check_value("aw_id", axi_id_t'(aw_count % NUM_TID), axi_master_aw_id_o);
         assert (aw_count - b_count < NUM_TID) else begin
            n_errors++;
            $display("ERROR: AW issued with all %0d ids still in use", NUM_TID);
         end
         sid_of_id[axi_master_aw_id_o] = cmd_sid[aw_count];
         aw_count++;
      end
      if (axi_master_w_valid_o && axi_master_w_ready_i) begin
         ref_burst(cmd_add[w_burst], cmd_bytes[w_burst], exp_addr, exp_len, beats);
         assert (beat_q.size() > 0) else begin
            n_errors++;
            $display("ERROR: W beat seen without a granted source beat");
         end
         beat = beat_q.pop_front();
         check_value("w_data", beat[63:0], axi_master_w_data_o);
         check_value("w_strb", beat[71:64], axi_master_w_strb_o);
         check_value("w_last", w_beat == beats - 1, axi_master_w_last_o);
         w_count++;
         if (w_beat == beats - 1) begin
            w_beat = 0;
            w_burst++;
         end else begin
            w_beat++;
         end
      end
      // Pulse exactly one cycle after each B handshake
      if (arst_n_i) begin
         check_value("synch_req", synch_due, tx_synch_req_o);
      end
      if (synch_due) begin
         check_value("synch_sid", synch_exp, tx_synch_sid_o);
         synch_count++;
      end
      synch_due = axi_master_b_valid_i && axi_master_b_ready_o;
      if (synch_due) begin
         synch_exp = sid_of_id[axi_master_b_id_i];
         b_count++;
      end
   end

endmodule

// ==== files.f ====
src/ext_axi_pkg.sv
src/ext_cmd_pkg.sv
src/ext_cmd_queue.sv
src/ext_tid_gen.sv
src/ext_sid_buf.sv
src/ext_tx_fsm.sv
src/ext_tx_unit.sv
sim/ext_tx_unit_sva.sv
sim/tb_ext_tx_unit.sv

// ==== Bender.yml ====
package:
  name: ext_tx_unit

sources:
  - src/ext_axi_pkg.sv
  - src/ext_cmd_pkg.sv
  - src/ext_cmd_queue.sv
  - src/ext_tid_gen.sv
  - src/ext_sid_buf.sv
  - src/ext_tx_fsm.sv
  - src/ext_tx_unit.sv
  - target: simulation
    files:
      - sim/ext_tx_unit_sva.sv
      - sim/tb_ext_tx_unit.sv
